// File: rtl/lsu_defines.svh
// ==========================================================================
// width and depth macros for the load/store unit
// include in any module that sizes ports or memory
// ==========================================================================
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data path width in bits
`define LSU_XLEN 32

// byte address width
`define LSU_ADDR_WIDTH 32

// data memory size in 32-bit words
`define LSU_DMEM_DEPTH 64
// log2 of the depth, selects the word
`define LSU_DMEM_INDEX_WIDTH 6

`endif

// File: rtl/rv_mem_pkg.sv
// ==========================================================================
// memory opcodes as seen by the requester
// reference the enum as rv_mem_pkg::mem_op_e
// ==========================================================================
`default_nettype none

package rv_mem_pkg;

    // one code per RV32I load/store instruction
    // op_none marks an idle request slot
    typedef enum logic [3:0] {
        op_none = 4'd0,
        // loads, signed
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        // loads, zero extended
        op_lbu  = 4'd4,
        op_lhu  = 4'd5,
        // stores
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } mem_op_e;

endpackage

`default_nettype wire

// File: rtl/lsu_pkg.sv
// ==========================================================================
// types passed between the internal pipeline stages
// ==========================================================================
`default_nettype none

package lsu_pkg;

    // access size, same code as the dmem store type
    // value 3 is reserved and never issued
    typedef enum logic [1:0] {
        // one byte lane
        width_byte = 2'd0,
        // two lanes, low or high half
        width_half = 2'd1,
        // whole word
        width_word = 2'd2
    } mem_width_e;

endpackage

`default_nettype wire

// File: rtl/lsu_addr_stage.sv
// ==========================================================================
// stage 1 of the LSU: effective address, opcode decode, alignment check
// outputs are registered and feed dmem and the load-align stage
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module lsu_addr_stage (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        req,
    input  wire rv_mem_pkg::mem_op_e         op,
    input  wire logic [`LSU_ADDR_WIDTH-1:0]  base,
    input  wire logic [`LSU_ADDR_WIDTH-1:0]  offset,
    input  wire logic [`LSU_XLEN-1:0]        store_data,
    output logic                             mem_write,
    output logic                             mem_read,
    output logic [`LSU_ADDR_WIDTH-1:0]       addr,
    output lsu_pkg::mem_width_e              width,
    output logic [`LSU_XLEN-1:0]             write_data,
    output logic                             load_unsigned,
    output logic                             fault_req
);

    logic [`LSU_ADDR_WIDTH-1:0] eff_addr;
    logic                       is_load;
    logic                       is_store;
    logic                       is_unsigned;
    logic                       misaligned;
    lsu_pkg::mem_width_e        width_d;

    // base + offset, wraps like the ISA add
    assign eff_addr = base + offset;

    // opcode decode
    always_comb begin
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_unsigned = 1'b0;
        width_d     = lsu_pkg::width_word;
        case (op)
            rv_mem_pkg::op_lb: begin
                is_load = 1'b1;
                width_d = lsu_pkg::width_byte;
            end
            rv_mem_pkg::op_lh: begin
                is_load = 1'b1;
                width_d = lsu_pkg::width_half;
            end
            rv_mem_pkg::op_lw: begin
                is_load = 1'b1;
            end
            rv_mem_pkg::op_lbu: begin
                is_load     = 1'b1;
                is_unsigned = 1'b1;
                width_d     = lsu_pkg::width_byte;
            end
            rv_mem_pkg::op_lhu: begin
                is_load     = 1'b1;
                is_unsigned = 1'b1;
                width_d     = lsu_pkg::width_half;
            end
            rv_mem_pkg::op_sb: begin
                is_store = 1'b1;
                width_d  = lsu_pkg::width_byte;
            end
            rv_mem_pkg::op_sh: begin
                is_store = 1'b1;
                width_d  = lsu_pkg::width_half;
            end
            rv_mem_pkg::op_sw: begin
                is_store = 1'b1;
            end
            // op_none and unused codes do nothing
            default: begin
                is_load  = 1'b0;
                is_store = 1'b0;
            end
        endcase
    end

    // halfword needs bit 0 clear, word needs bits 1:0 clear
    always_comb begin
        case (width_d)
            lsu_pkg::width_half: misaligned = eff_addr[0];
            lsu_pkg::width_word: misaligned = |eff_addr[1:0];
            default:             misaligned = 1'b0;
        endcase
    end

    // strobes, one cycle each
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_write <= 1'b0;
            mem_read  <= 1'b0;
            fault_req <= 1'b0;
        end else begin
            mem_write <= req && is_store && !misaligned;
            mem_read  <= req && is_load && !misaligned;
            // a bad access replaces the memory strobe
            fault_req <= req && (is_load || is_store) && misaligned;
        end
    end

    // payload, only loaded on a request
    always_ff @(posedge clk) begin
        if (req) begin
            addr          <= eff_addr;
            width         <= width_d;
            write_data    <= store_data;
            load_unsigned <= is_unsigned;
        end
    end

    // misaligned store must never reach memory
    a_no_write_with_fault: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_write && fault_req)
    ) else $error("mem_write and fault_req high together");

endmodule

`default_nettype wire

// File: rtl/dmem.sv
// ==========================================================================
// stage 2 of the LSU: word-organised data memory
// byte, halfword and word lane writes; read data registered every cycle
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module dmem (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        mem_write,
    input  wire logic [`LSU_ADDR_WIDTH-1:0]  addr,
    input  wire lsu_pkg::mem_width_e         width,
    input  wire logic [`LSU_XLEN-1:0]        write_data,
    output logic [`LSU_XLEN-1:0]             read_data
);

    logic [`LSU_XLEN-1:0]             memory [`LSU_DMEM_DEPTH];
    logic [`LSU_DMEM_INDEX_WIDTH-1:0] index;

    // word select, byte offset dropped
    assign index = addr[`LSU_DMEM_INDEX_WIDTH+1:2];

    // read every cycle
    // a store one cycle earlier is already in the array
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else begin
            read_data <= memory[index];
        end
    end

    // lane writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LSU_DMEM_DEPTH; i++) begin
                memory[i] <= '0;
            end
        end else if (mem_write) begin
            case (width)
                lsu_pkg::width_byte: begin
                    // byte goes to lane addr[1:0]
                    case (addr[1:0])
                        2'd0: memory[index][7:0]   <= write_data[7:0];
                        2'd1: memory[index][15:8]  <= write_data[7:0];
                        2'd2: memory[index][23:16] <= write_data[7:0];
                        2'd3: memory[index][31:24] <= write_data[7:0];
                        default: memory[index] <= memory[index];
                    endcase
                end
                lsu_pkg::width_half: begin
                    // low or high half by addr[1]
                    if (addr[1]) begin
                        memory[index][31:16] <= write_data[15:0];
                    end else begin
                        memory[index][15:0] <= write_data[15:0];
                    end
                end
                lsu_pkg::width_word: begin
                    memory[index] <= write_data;
                end
                // reserved width, array untouched
                default: begin
                    memory[index] <= memory[index];
                end
            endcase
        end
    end

    // stage 1 only issues the three legal widths
    a_write_width_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_write |-> (width inside {lsu_pkg::width_byte, lsu_pkg::width_half,
                                     lsu_pkg::width_word})
    ) else $error("store issued with reserved width %0d", width);

    // upper address bits would alias onto a lower word
    a_write_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_write |-> ((addr >> 2) < `LSU_DMEM_DEPTH)
    ) else $error("store address 0x%08h beyond memory depth", addr);

endmodule

`default_nettype wire

// File: rtl/lsu_load_align.sv
// ==========================================================================
// stage 3 of the LSU: lane select and extension of load data
// also reports misaligned accesses with the same three-cycle latency
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module lsu_load_align (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        mem_read,
    input  wire logic                        fault_req,
    input  wire logic [`LSU_ADDR_WIDTH-1:0]  addr,
    input  wire lsu_pkg::mem_width_e         width,
    input  wire logic                        load_unsigned,
    input  wire logic [`LSU_XLEN-1:0]        read_data,
    output logic                             load_valid,
    output logic [`LSU_XLEN-1:0]             load_data,
    output logic                             fault,
    output logic [`LSU_ADDR_WIDTH-1:0]       fault_addr
);

    // sideband, one cycle behind stage 1 to meet read_data
    logic                       load_req;
    logic                       fault_pending;
    logic [`LSU_ADDR_WIDTH-1:0] addr_q;
    lsu_pkg::mem_width_e        width_q;
    logic                       unsigned_q;

    logic [1:0]           addr_lo;
    logic [7:0]           byte_sel;
    logic [15:0]          half_sel;
    logic [`LSU_XLEN-1:0] aligned;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_req      <= 1'b0;
            fault_pending <= 1'b0;
        end else begin
            load_req      <= mem_read;
            fault_pending <= fault_req;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_read || fault_req) begin
            addr_q     <= addr;
            width_q    <= width;
            unsigned_q <= load_unsigned;
        end
    end

    assign addr_lo = addr_q[1:0];

    // pick the addressed lanes
    assign byte_sel = read_data[8*addr_lo +: 8];
    assign half_sel = addr_lo[1] ? read_data[31:16] : read_data[15:0];

    // sign or zero extend
    always_comb begin
        case (width_q)
            lsu_pkg::width_byte:
                aligned = {{(`LSU_XLEN-8){byte_sel[7] & ~unsigned_q}}, byte_sel};
            lsu_pkg::width_half:
                aligned = {{(`LSU_XLEN-16){half_sel[15] & ~unsigned_q}}, half_sel};
            default:
                aligned = read_data;
        endcase
    end

    // result pulses; data and address held until the next event
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_valid <= 1'b0;
            fault      <= 1'b0;
            load_data  <= '0;
            fault_addr <= '0;
        end else begin
            load_valid <= load_req;
            fault      <= fault_pending;
            if (load_req) begin
                load_data <= aligned;
            end
            if (fault_pending) begin
                fault_addr <= addr_q;
            end
        end
    end

    // stage 1 decides load or fault per request, never both
    a_valid_xor_fault: assert property (
        @(posedge clk) disable iff (!rst_n) !(load_valid && fault)
    ) else $error("load_valid and fault high together");

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
// ==========================================================================
// load/store unit top: address stage, data memory, load alignment
// fixed three-cycle latency from request to load_valid or fault
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module lsu_top (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        req,
    input  wire rv_mem_pkg::mem_op_e         op,
    input  wire logic [`LSU_ADDR_WIDTH-1:0]  base,
    input  wire logic [`LSU_ADDR_WIDTH-1:0]  offset,
    input  wire logic [`LSU_XLEN-1:0]        store_data,
    output logic                             load_valid,
    output logic [`LSU_XLEN-1:0]             load_data,
    output logic                             fault,
    output logic [`LSU_ADDR_WIDTH-1:0]       fault_addr
);

    // stage 1 outputs
    logic                       mem_write;
    logic                       mem_read;
    logic [`LSU_ADDR_WIDTH-1:0] addr;
    lsu_pkg::mem_width_e        width;
    logic [`LSU_XLEN-1:0]       write_data;
    logic                       load_unsigned;
    logic                       fault_req;

    // stage 2 output
    logic [`LSU_XLEN-1:0]       read_data;

    lsu_addr_stage u_addr_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .op            (op),
        .base          (base),
        .offset        (offset),
        .store_data    (store_data),
        .mem_write     (mem_write),
        .mem_read      (mem_read),
        .addr          (addr),
        .width         (width),
        .write_data    (write_data),
        .load_unsigned (load_unsigned),
        .fault_req     (fault_req)
    );

    dmem u_dmem (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_write  (mem_write),
        .addr       (addr),
        .width      (width),
        .write_data (write_data),
        .read_data  (read_data)
    );

    // sideband taps stage 1 directly, aligned by its own register
    lsu_load_align u_load_align (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_read      (mem_read),
        .fault_req     (fault_req),
        .addr          (addr),
        .width         (width),
        .load_unsigned (load_unsigned),
        .read_data     (read_data),
        .load_valid    (load_valid),
        .load_data     (load_data),
        .fault         (fault),
        .fault_addr    (fault_addr)
    );

endmodule

`default_nettype wire

// File: verif/lsu_tb.sv
// ==========================================================================
// testbench for the LSU: directed and random load/store traffic
// concurrent assertions check each result three cycles after its request
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module lsu_tb;

    localparam int clk_half     = 50;
    localparam int drain_limit  = 16;
    localparam int run_limit_ns = 200000;

    // result kinds carried by the expected pipeline
    localparam logic [1:0] kind_none  = 2'd0;
    localparam logic [1:0] kind_load  = 2'd1;
    localparam logic [1:0] kind_fault = 2'd2;

    logic                       clk;
    logic                       rst_n;
    logic                       req;
    rv_mem_pkg::mem_op_e        op;
    logic [`LSU_ADDR_WIDTH-1:0] base;
    logic [`LSU_ADDR_WIDTH-1:0] offset;
    logic [`LSU_XLEN-1:0]       store_data;
    logic                       load_valid;
    logic [`LSU_XLEN-1:0]       load_data;
    logic                       fault;
    logic [`LSU_ADDR_WIDTH-1:0] fault_addr;

    // byte-wide reference copy of dmem, little endian
    logic [7:0]  model [4*`LSU_DMEM_DEPTH];
    logic [15:0] lfsr;

    // expected result of the request on the inputs
    logic [1:0]  exp_kind;
    logic [31:0] exp_val;
    // same, delayed to line up with the DUT outputs
    logic [1:0]  kind_d1;
    logic [1:0]  kind_d2;
    logic [1:0]  kind_d3;
    logic [31:0] val_d1;
    logic [31:0] val_d2;
    logic [31:0] val_d3;

    int value_errors;
    int pulse_errors;
    int timeout_errors;

    lsu_top u_lsu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .base       (base),
        .offset     (offset),
        .store_data (store_data),
        .load_valid (load_valid),
        .load_data  (load_data),
        .fault      (fault),
        .fault_addr (fault_addr)
    );

    always #(clk_half) clk = ~clk;

    // three stages, same edges as the DUT pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kind_d1 <= kind_none;
            kind_d2 <= kind_none;
            kind_d3 <= kind_none;
            val_d1  <= '0;
            val_d2  <= '0;
            val_d3  <= '0;
        end else begin
            kind_d1 <= exp_kind;
            kind_d2 <= kind_d1;
            kind_d3 <= kind_d2;
            val_d1  <= exp_val;
            val_d2  <= val_d1;
            val_d3  <= val_d2;
        end
    end

    a_load_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) (kind_d3 == kind_load) |-> load_valid
    ) else begin
        pulse_errors++;
        $display("load_valid missing three cycles after a load at t=%0t", $time);
    end

    a_load_value: assert property (
        @(posedge clk) disable iff (!rst_n) (kind_d3 == kind_load) |-> (load_data == val_d3)
    ) else begin
        value_errors++;
        $display("Fail t=%0t load_data got %08h expected %08h",
                 $time, $sampled(load_data), $sampled(val_d3));
    end

    a_fault_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) (kind_d3 == kind_fault) |-> fault
    ) else begin
        pulse_errors++;
        $display("fault missing three cycles after a misaligned access at t=%0t", $time);
    end

    a_fault_addr: assert property (
        @(posedge clk) disable iff (!rst_n) (kind_d3 == kind_fault) |-> (fault_addr == val_d3)
    ) else begin
        value_errors++;
        $display("Fail t=%0t fault_addr got %08h expected %08h",
                 $time, $sampled(fault_addr), $sampled(val_d3));
    end

    // no pulse without a matching request
    a_no_extra_load: assert property (
        @(posedge clk) disable iff (!rst_n) load_valid |-> (kind_d3 == kind_load)
    ) else begin
        pulse_errors++;
        $display("load_valid pulsed with no load in flight at t=%0t", $time);
    end

    a_no_extra_fault: assert property (
        @(posedge clk) disable iff (!rst_n) fault |-> (kind_d3 == kind_fault)
    ) else begin
        pulse_errors++;
        $display("fault pulsed with no misaligned access in flight at t=%0t", $time);
    end

    // Galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    // one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic [7:0] rand_word_addr();
        return {6'(take_bits(6)), 2'b00};
    endfunction

    function automatic logic is_load(input rv_mem_pkg::mem_op_e o);
        return o inside {rv_mem_pkg::op_lb, rv_mem_pkg::op_lh, rv_mem_pkg::op_lw,
                         rv_mem_pkg::op_lbu, rv_mem_pkg::op_lhu};
    endfunction

    // halfwords need an even address, words a multiple of four
    function automatic logic is_misaligned(input rv_mem_pkg::mem_op_e o, input logic [7:0] ea);
        case (o)
            rv_mem_pkg::op_lh, rv_mem_pkg::op_lhu, rv_mem_pkg::op_sh: return ea[0];
            rv_mem_pkg::op_lw, rv_mem_pkg::op_sw: return ea[1:0] != 2'd0;
            default: return 1'b0;
        endcase
    endfunction

    // extension rules of the RV32I loads
    function automatic logic [31:0] load_value(input rv_mem_pkg::mem_op_e o,
                                               input logic [7:0] ea);
        logic [7:0]  b;
        logic [15:0] h;
        b = model[ea];
        h = {model[ea + 8'd1], model[ea]};
        case (o)
            rv_mem_pkg::op_lb:  return {{24{b[7]}}, b};
            rv_mem_pkg::op_lbu: return {24'd0, b};
            rv_mem_pkg::op_lh:  return {{16{h[15]}}, h};
            rv_mem_pkg::op_lhu: return {16'd0, h};
            default: return {model[ea + 8'd3], model[ea + 8'd2], model[ea + 8'd1], model[ea]};
        endcase
    endfunction

    // loads leave the model alone
    function automatic void update_model(input rv_mem_pkg::mem_op_e o, input logic [7:0] ea,
                                         input logic [31:0] d);
        case (o)
            rv_mem_pkg::op_sb: model[ea] = d[7:0];
            rv_mem_pkg::op_sh: begin
                model[ea]        = d[7:0];
                model[ea + 8'd1] = d[15:8];
            end
            rv_mem_pkg::op_sw: begin
                model[ea]        = d[7:0];
                model[ea + 8'd1] = d[15:8];
                model[ea + 8'd2] = d[23:16];
                model[ea + 8'd3] = d[31:24];
            end
            default: begin
            end
        endcase
    endfunction

    // one request; base and random offset sum to ea
    task automatic issue(input rv_mem_pkg::mem_op_e o, input logic [7:0] ea,
                         input logic [31:0] d);
        logic [31:0] off;
        logic        bad;
        off = take_bits(8);
        bad = is_misaligned(o, ea);
        @(posedge clk);
        #1;
        req        = 1'b1;
        op         = o;
        offset     = off;
        base       = {24'd0, ea} - off;
        store_data = d;
        if (bad) begin
            // memory untouched, fault carries the effective address
            exp_kind = kind_fault;
            exp_val  = {24'd0, ea};
        end else if (is_load(o)) begin
            exp_kind = kind_load;
            exp_val  = load_value(o, ea);
        end else begin
            exp_kind = kind_none;
            exp_val  = '0;
            update_model(o, ea, d);
        end
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        req      = 1'b0;
        op       = rv_mem_pkg::op_none;
        exp_kind = kind_none;
        exp_val  = '0;
    endtask

    // wait until every request in flight has been checked
    task automatic drain();
        int cycles;
        idle();
        cycles = 0;
        while ((kind_d1 != kind_none || kind_d2 != kind_none || kind_d3 != kind_none)
               && cycles < drain_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (kind_d1 != kind_none || kind_d2 != kind_none || kind_d3 != kind_none) begin
            timeout_errors++;
            $display("timeout: requests still in flight after %0d idle cycles", cycles);
        end
    endtask

    initial begin
        logic [7:0]  wa;
        logic [7:0]  b;
        logic [15:0] h;
        logic [3:0]  code;
        clk            = 1'b0;
        rst_n          = 1'b0;
        req            = 1'b0;
        op             = rv_mem_pkg::op_none;
        base           = '0;
        offset         = '0;
        store_data     = '0;
        exp_kind       = kind_none;
        exp_val        = '0;
        lfsr           = 16'd36;
        value_errors   = 0;
        pulse_errors   = 0;
        timeout_errors = 0;
        for (int i = 0; i < 4*`LSU_DMEM_DEPTH; i++) begin
            model[i] = 8'd0;
        end

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // outputs cleared by reset
        assert (load_data == '0) else begin
            value_errors++;
            $display("Fail t=%0t load_data got %08h expected %08h", $time, load_data, 32'd0);
        end
        assert (fault_addr == '0) else begin
            value_errors++;
            $display("Fail t=%0t fault_addr got %08h expected %08h", $time, fault_addr, 32'd0);
        end
        // quiet outputs while idle
        repeat (3) idle();

        // cleared memory reads zero
        for (int i = 0; i < 4; i++) begin
            issue(rv_mem_pkg::op_lw, rand_word_addr(), '0);
        end
        drain();

        // word store then load, first with a gap, then back to back
        for (int i = 0; i < 4; i++) begin
            wa = rand_word_addr();
            issue(rv_mem_pkg::op_sw, wa, take_bits(32));
            idle();
            issue(rv_mem_pkg::op_lw, wa, '0);
        end
        for (int i = 0; i < 4; i++) begin
            wa = rand_word_addr();
            issue(rv_mem_pkg::op_sw, wa, take_bits(32));
            issue(rv_mem_pkg::op_lw, wa, '0);
        end
        drain();

        // each byte lane, sign bit set on even lanes
        wa = rand_word_addr();
        issue(rv_mem_pkg::op_sw, wa, take_bits(32));
        for (int lane = 0; lane < 4; lane++) begin
            b = {~lane[0], 7'(take_bits(7))};
            issue(rv_mem_pkg::op_sb, wa + 8'(lane), {24'(take_bits(24)), b});
            issue(rv_mem_pkg::op_lw, wa, '0);
            issue(rv_mem_pkg::op_lb, wa + 8'(lane), '0);
            issue(rv_mem_pkg::op_lbu, wa + 8'(lane), '0);
        end
        drain();

        // low half negative, high half positive
        wa = rand_word_addr();
        issue(rv_mem_pkg::op_sw, wa, take_bits(32));
        for (int half = 0; half < 2; half++) begin
            h = {~half[0], 15'(take_bits(15))};
            issue(rv_mem_pkg::op_sh, wa + 8'(2*half), {16'(take_bits(16)), h});
            issue(rv_mem_pkg::op_lw, wa, '0);
            issue(rv_mem_pkg::op_lh, wa + 8'(2*half), '0);
            issue(rv_mem_pkg::op_lhu, wa + 8'(2*half), '0);
        end
        drain();

        // misaligned accesses, then the old word must still be there
        wa = rand_word_addr();
        issue(rv_mem_pkg::op_sw, wa, take_bits(32));
        issue(rv_mem_pkg::op_lh, wa + 8'd1, '0);
        issue(rv_mem_pkg::op_lw, wa + 8'd2, '0);
        issue(rv_mem_pkg::op_sh, wa + 8'd3, take_bits(32));
        issue(rv_mem_pkg::op_sw, wa + 8'd1, take_bits(32));
        issue(rv_mem_pkg::op_lhu, wa + 8'd3, '0);
        issue(rv_mem_pkg::op_lw, wa, '0);
        drain();

        // random mix, one request per cycle
        for (int i = 0; i < 200; i++) begin
            code = 4'(take_bits(3)) + 4'd1;
            issue(rv_mem_pkg::mem_op_e'(code), 8'(take_bits(8)), take_bits(32));
        end
        drain();

        $display("errors: value %0d, pulse %0d, timeout %0d",
                 value_errors, pulse_errors, timeout_errors);
        if (value_errors + pulse_errors + timeout_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // overall limit on the run
    initial begin
        #(run_limit_ns);
        $display("timeout: run did not finish within %0d ns", run_limit_ns);
        $display("errors: value %0d, pulse %0d, timeout %0d",
                 value_errors, pulse_errors, timeout_errors + 1);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/rv_mem_pkg.sv
rtl/lsu_pkg.sv
rtl/lsu_addr_stage.sv
rtl/dmem.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
verif/lsu_tb.sv

// File: Makefile
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       := lsu_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
